// ==== run_sim.sh ====
#!/bin/sh
# Builds the fetch interface testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_instr_obi_fetch -f sources.f
./obj_dir/Vtb_instr_obi_fetch > sim.log 2>&1
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"

// ==== source/fetch_pkg.sv ====
/* Core-side fetch types and the entry kept per outstanding bus transaction */
`default_nettype none

package fetch_pkg;
  import obi_pkg::*;

  // Fetch address from the core, taken when valid and ready meet
  typedef struct packed {
    logic                  valid;
    logic [obi_addr_w-1:0] addr;
  } fetch_req_t;

  // Response back to the core
  // gnt_err marks a grant parity fault seen around the address phase
  typedef struct packed {
    logic [obi_addr_w-1:0] addr;
    logic [obi_data_w-1:0] rdata;
    logic                  gnt_err;
  } fetch_resp_t;

  // One entry per granted address, waiting for its rvalid
  typedef struct packed {
    logic [obi_addr_w-1:0] addr;
    logic                  gnt_err;
  } track_entry_t;

endpackage

`default_nettype wire

// ==== source/fetch_req_stage.sv ====
/* Address side of the fetch interface: takes core fetches, runs the OBI address
   phase, tags each grant with its parity fault and limits outstanding work */
`timescale 1ns/1ps
`default_nettype none

module fetch_req_stage
  import obi_pkg::*;
  import fetch_pkg::*;
#(
  parameter int max_outstnd = 4
) (
  input  logic         clk,
  input  logic         rst_n,
  input  fetch_req_t   fetch_req,
  output logic         fetch_ready,
  output obi_req_t     obi_req,
  input  logic         gnt,
  input  logic         gntpar,
  output logic         track_push,
  output track_entry_t track_entry,
  input  logic         released
);

  // One extra bit so credits plus a pending phase never wrap
  localparam int cnt_w = $clog2(max_outstnd + 1) + 1;

  logic                  pend_valid;
  logic [obi_addr_w-1:0] pend_addr;
  logic                  granted;
  logic                  fetch_acc;
  logic                  gnt_fault;
  logic                  ready_en;
  logic [cnt_w-1:0]      credit_cnt;
  logic [cnt_w-1:0]      in_flight;

  gntpar_checker gntpar_chk0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .gnt       (gnt),
    .gntpar    (gntpar),
    .gnt_fault (gnt_fault)
  );

  //////////////////////////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////////////////////////

  assign granted   = pend_valid & gnt;
  assign fetch_acc = fetch_req.valid & fetch_ready;

  // Granted transactions plus a still-pending address phase
  assign in_flight = credit_cnt + cnt_w'(pend_valid);

  // Slot free when nothing pends or the pending one goes now
  assign fetch_ready = ready_en & (~pend_valid | gnt) & (in_flight < cnt_w'(max_outstnd));

  // Address phase straight from the pending register
  assign obi_req = '{req: pend_valid, addr: pend_addr};

  // Every grant opens a tracker entry with the fault seen around it
  assign track_push  = granted;
  assign track_entry = '{addr: pend_addr, gnt_err: gnt_fault};

  //////////////////////////////////////////////////////////////////////
  // Control state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready_en   <= 1'b0;
      pend_valid <= 1'b0;
      credit_cnt <= '0;
    end else begin
      // Core sees ready only from the first clock after reset
      ready_en <= 1'b1;
      // New fetch replaces a phase that is granted this cycle
      if (fetch_acc) begin
        pend_valid <= 1'b1;
      end else if (granted) begin
        pend_valid <= 1'b0;
      end
      // Credit taken on grant, returned when the core takes the response
      case ({granted, released})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  // Address payload, held while req waits for gnt
  always_ff @(posedge clk) begin
    if (fetch_acc) begin
      pend_addr <= fetch_req.addr;
    end
  end

endmodule

`default_nettype wire

// ==== source/fetch_resp_stage.sv ====
/* Response side of the fetch interface: matches in-order OBI responses with their
   tracker entries and buffers the tagged results until the core takes them */
`timescale 1ns/1ps
`default_nettype none

module fetch_resp_stage
  import obi_pkg::*;
  import fetch_pkg::*;
#(
  parameter int max_outstnd = 4
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         track_push,
  input  track_entry_t track_entry,
  input  obi_resp_t    obi_resp,
  output fetch_resp_t  rsp,
  output logic         rsp_valid,
  input  logic         rsp_ready,
  output logic         released
);

  track_entry_t trk_head;
  fetch_resp_t  joined;
  logic         buf_empty;

  //////////////////////////////////////////////////////////////////////
  // Tracker, one entry per granted address
  //////////////////////////////////////////////////////////////////////

  // Responses are in order, so each rvalid belongs to the head entry
  inorder_fifo #(
    .payload_t (track_entry_t),
    .depth     (max_outstnd)
  ) track_fifo0 (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (track_push),
    .wdata (track_entry),
    .pop   (obi_resp.rvalid),
    .rdata (trk_head),
    .empty (),
    .full  ()
  );

  // Join address and fault tag with the returned data
  assign joined = '{addr: trk_head.addr, rdata: obi_resp.rdata, gnt_err: trk_head.gnt_err};

  //////////////////////////////////////////////////////////////////////
  // Response buffer towards the core
  //////////////////////////////////////////////////////////////////////

  // Credits in the request stage keep this from overflowing
  inorder_fifo #(
    .payload_t (fetch_resp_t),
    .depth     (max_outstnd)
  ) rsp_fifo0 (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (obi_resp.rvalid),
    .wdata (joined),
    .pop   (released),
    .rdata (rsp),
    .empty (buf_empty),
    .full  ()
  );

  assign rsp_valid = ~buf_empty;

  // Core handshake frees the entry and returns a credit
  assign released = rsp_valid & rsp_ready;

endmodule

`default_nettype wire

// ==== source/gntpar_checker.sv ====
/* Grant parity check for the OBI address phase; flags a fault when gntpar fails to
   be the inverse of gnt in this cycle or in the one before */
`timescale 1ns/1ps
`default_nettype none

module gntpar_checker (
  input  logic clk,
  input  logic rst_n,
  input  logic gnt,
  input  logic gntpar,
  output logic gnt_fault
);

  // Mismatch in the current cycle
  logic mismatch;
  // Mismatch seen one cycle earlier
  logic mismatch_q;

  // gntpar is complementary, so equal values are a fault
  assign mismatch = (gntpar == gnt);

  //////////////////////////////////////////////////////////////////////
  // One-cycle fault history
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mismatch_q <= 1'b0;
    end else begin
      mismatch_q <= mismatch;
    end
  end

  // A fault just before a grant still marks that grant
  assign gnt_fault = mismatch | mismatch_q;

endmodule

`default_nettype wire

// ==== source/inorder_fifo.sv ====
/* Small circular FIFO with a type-parameterized payload; used for the transaction
   tracker and for the response buffer towards the core */
`timescale 1ns/1ps
`default_nettype none

module inorder_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  depth     = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t wdata,
  input  logic     pop,
  output payload_t rdata,
  output logic     empty,
  output logic     full
);

  // Pointer needs at least one bit even for a single entry
  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t           mem [depth];
  logic [ptr_w-1:0]   wr_ptr;
  logic [ptr_w-1:0]   rd_ptr;
  logic [cnt_w-1:0]   count;
  logic               do_push;
  logic               do_pop;

  assign empty = (count == '0);
  assign full  = (count == cnt_w'(depth));

  // Pop only when data is there; a full FIFO takes a push only alongside a pop
  assign do_pop  = pop & ~empty;
  assign do_push = push & (~full | do_pop);

  // Head of the queue is visible without a read strobe
  assign rdata = mem[rd_ptr];

  //////////////////////////////////////////////////////////////////////
  // Entry storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Pointers and fill count
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Wrap at depth, which need not be a power of two
      if (do_push) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/instr_obi_fetch.sv ====
/* Instruction-fetch OBI interface top; wire core fetch ports and the OBI bus here,
   max_outstnd sets the credit limit and both FIFO depths */
`timescale 1ns/1ps
`default_nettype none

module instr_obi_fetch
  import obi_pkg::*;
  import fetch_pkg::*;
#(
  parameter int max_outstnd = 4
) (
  input  logic        clk,
  input  logic        rst_n,
  // Core fetch requests
  input  fetch_req_t  fetch_req,
  output logic        fetch_ready,
  // Core responses
  output fetch_resp_t rsp,
  output logic        rsp_valid,
  input  logic        rsp_ready,
  // OBI instruction bus
  output obi_req_t    obi_req,
  input  logic        gnt,
  input  logic        gntpar,
  input  obi_resp_t   obi_resp
);

  // Request stage to response stage
  logic         track_push;
  track_entry_t track_entry;
  // Credit return
  logic         released;

  fetch_req_stage #(
    .max_outstnd (max_outstnd)
  ) req_stage0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_req   (fetch_req),
    .fetch_ready (fetch_ready),
    .obi_req     (obi_req),
    .gnt         (gnt),
    .gntpar      (gntpar),
    .track_push  (track_push),
    .track_entry (track_entry),
    .released    (released)
  );

  fetch_resp_stage #(
    .max_outstnd (max_outstnd)
  ) resp_stage0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .track_push  (track_push),
    .track_entry (track_entry),
    .obi_resp    (obi_resp),
    .rsp         (rsp),
    .rsp_valid   (rsp_valid),
    .rsp_ready   (rsp_ready),
    .released    (released)
  );

endmodule

`default_nettype wire

// ==== source/obi_pkg.sv ====
/* Bus-side types for the OBI instruction port: address phase and response phase
   structs plus the bus widths, shared by the fetch interface and its testbench */
`default_nettype none

package obi_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////////////////////////

  localparam int obi_addr_w = 32;
  localparam int obi_data_w = 32;

  //////////////////////////////////////////////////////////////////////
  // Address phase, driven by the manager
  //////////////////////////////////////////////////////////////////////

  // req and addr hold steady until a cycle with gnt high
  typedef struct packed {
    logic                  req;
    logic [obi_addr_w-1:0] addr;
  } obi_req_t;

  //////////////////////////////////////////////////////////////////////
  // Response phase, driven by the subordinate
  //////////////////////////////////////////////////////////////////////

  // One rvalid cycle per granted address, always in order
  typedef struct packed {
    logic                  rvalid;
    logic [obi_data_w-1:0] rdata;
  } obi_resp_t;

endpackage

`default_nettype wire

// ==== sources.f ====
source/obi_pkg.sv
source/fetch_pkg.sv
source/gntpar_checker.sv
source/inorder_fifo.sv
source/fetch_req_stage.sv
source/fetch_resp_stage.sv
source/instr_obi_fetch.sv
tb/tb_clock.sv
tb/obi_mem_model.sv
tb/tb_instr_obi_fetch.sv

// ==== tb/obi_mem_model.sv ====
/* OBI subordinate model for the fetch testbench; random grant and response delays,
   rdata is the inverted address, gntpar is corrupted on selected cycles */
`timescale 1ns/1ps
`default_nettype none

module obi_mem_model
  import obi_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  obi_req_t  obi_req,
  input  logic      stray_en,
  output logic      gnt,
  output logic      gntpar,
  output obi_resp_t obi_resp
);

  // Granted addresses and the cycle their response is due
  logic [obi_addr_w-1:0] addr_q [$];
  int unsigned           due_q [$];
  int unsigned           cyc;
  int unsigned           due;
  int unsigned           last_due;
  int unsigned           gnt_wait;
  logic                  armed;
  logic                  bad_par;

  initial begin
    gnt      = 1'b0;
    gntpar   = 1'b1;
    obi_resp = '0;
    cyc      = 0;
    last_due = 0;
    gnt_wait = 0;
    armed    = 1'b0;
  end

  // All outputs change on the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      cyc = cyc + 1;
      // Oldest granted address answers once its delay is up
      obi_resp = '0;
      if (due_q.size() > 0 && due_q[0] <= cyc) begin
        obi_resp = '{rvalid: 1'b1, rdata: ~addr_q[0]};
        void'(addr_q.pop_front());
        void'(due_q.pop_front());
      end
      // Fresh 0 to 3 cycle grant delay for each address phase
      gnt = 1'b0;
      if (obi_req.req && !armed) begin
        gnt_wait = $urandom_range(3, 0);
        armed    = 1'b1;
      end
      if (armed && gnt_wait == 0) begin
        gnt   = 1'b1;
        armed = 1'b0;
        // Response due 1 to 4 cycles later and never ahead of the one before
        due = cyc + $urandom_range(4, 1);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        addr_q.push_back(obi_req.addr);
        due_q.push_back(due);
      end else if (armed) begin
        gnt_wait--;
      end
      // Wrong parity on grants to bits 5:4 == 3 and on random idle cycles in stray mode
      bad_par = gnt ? (obi_req.addr[5:4] == 2'b11) : (stray_en && $urandom_range(7, 0) == 0);
      gntpar  = bad_par ? gnt : ~gnt;
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
/* Clock and reset source for the fetch testbench; reset is released on a falling edge */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int half_period  = 5,
  parameter int reset_cycles = 16
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // Low across reset_cycles rising edges
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb/tb_instr_obi_fetch.sv ====
/* Testbench top for the OBI instruction fetch interface; six tests with a queue
   scoreboard, assertion checks, a watchdog and a closing report */
`timescale 1ns/1ps
`default_nettype none

module tb_instr_obi_fetch
  import obi_pkg::*;
  import fetch_pkg::*;
();

  localparam int max_outstnd  = 4;
  localparam int reset_cycles = 16;
  localparam int n_seq        = 12;
  localparam int n_tag        = 8;
  localparam int n_stray      = 16;
  localparam int n_burst      = 16;
  localparam int n_fetch      = n_seq + n_tag + n_stray + max_outstnd + n_burst;

  logic        clk;
  logic        rst_n;
  fetch_req_t  fetch_req;
  logic        fetch_ready;
  fetch_resp_t rsp;
  logic        rsp_valid;
  logic        rsp_ready;
  obi_req_t    obi_req;
  logic        gnt;
  logic        gntpar;
  obi_resp_t   obi_resp;
  logic        stray_en;
  logic        tag_rule;
  logic        burst_done;
  logic [31:0] addr_v;

  // Scoreboard of accepted addresses and the fault seen at each grant
  logic [31:0] issue_q [$];
  logic        fault_q [$];
  logic [31:0] head_addr;
  logic        head_err;
  logic        head_ok;
  logic        mis_prev;
  int          acc_cnt = 0;
  int          rsp_cnt = 0;
  int          rv_cnt = 0;
  int          err_cnt = 0;
  int          err_mark = 0;
  int          test_num = 0;
  int          hold_acc;
  int          hold_rv;

  tb_clock #(.reset_cycles(reset_cycles)) clk0 (.clk(clk), .rst_n(rst_n));

  instr_obi_fetch #(.max_outstnd(max_outstnd)) dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_req   (fetch_req),
    .fetch_ready (fetch_ready),
    .rsp         (rsp),
    .rsp_valid   (rsp_valid),
    .rsp_ready   (rsp_ready),
    .obi_req     (obi_req),
    .gnt         (gnt),
    .gntpar      (gntpar),
    .obi_resp    (obi_resp)
  );

  obi_mem_model mem0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .obi_req  (obi_req),
    .stray_en (stray_en),
    .gnt      (gnt),
    .gntpar   (gntpar),
    .obi_resp (obi_resp)
  );

  task automatic report_fail(input string msg);
    err_cnt++;
    $display("Fail %0t: %s", $time, msg);
  endtask

  task automatic end_test(input string name);
    test_num++;
    $display("Test %0d %s finished with %0d errors", test_num, name, err_cnt - err_mark);
    err_mark = err_cnt;
  endtask

  // Called on a falling edge and returns on the falling edge after acceptance
  task automatic issue_fetch(input logic [31:0] addr);
    int target;
    target          = acc_cnt + 1;
    fetch_req.valid = 1'b1;
    fetch_req.addr  = addr;
    @(negedge clk);
    while (acc_cnt < target) @(negedge clk);
    fetch_req.valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (rsp_cnt < acc_cnt) @(negedge clk);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Monitor and scoreboard
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst_n) begin
      mis_prev = 1'b0;
    end else begin
      if (rsp_valid && rsp_ready && issue_q.size() > 0 && fault_q.size() > 0) begin
        void'(issue_q.pop_front());
        void'(fault_q.pop_front());
        rsp_cnt++;
      end
      if (obi_resp.rvalid) begin
        rv_cnt++;
      end
      // Expected tag is a mismatch in this grant cycle or the one before
      if (obi_req.req && gnt) begin
        fault_q.push_back((gnt == gntpar) || mis_prev);
      end
      if (fetch_req.valid && fetch_ready) begin
        issue_q.push_back(fetch_req.addr);
        acc_cnt++;
      end
      mis_prev  = (gnt == gntpar);
      head_ok   = issue_q.size() > 0 && fault_q.size() > 0;
      head_addr = head_ok ? issue_q[0] : '0;
      head_err  = head_ok ? fault_q[0] : 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  assert property (@(posedge clk) !rst_n |-> !fetch_ready && !obi_req.req && !rsp_valid)
    else report_fail("handshake output high during reset");

  assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid && rsp_ready |-> head_ok && rsp.addr == head_addr
      && rsp.rdata == ~head_addr && rsp.gnt_err == head_err)
    else report_fail($sformatf("rsp addr %h rdata %h gnt_err %b, expected addr %h gnt_err %b",
      $sampled(rsp.addr), $sampled(rsp.rdata), $sampled(rsp.gnt_err),
      $sampled(head_addr), $sampled(head_err)));

  // Fault only on addresses with bits 5:4 set while no stray faults run
  assert property (@(posedge clk) disable iff (!rst_n)
      tag_rule && rsp_valid && rsp_ready |-> rsp.gnt_err == (head_addr[5:4] == 2'b11))
    else report_fail($sformatf("gnt_err %b for addr %h", $sampled(rsp.gnt_err),
      $sampled(head_addr)));

  assert property (@(posedge clk) disable iff (!rst_n)
      acc_cnt - rsp_cnt >= max_outstnd |-> !fetch_ready)
    else report_fail("fetch_ready high with every credit in use");

  assert property (@(posedge clk) disable iff (!rst_n)
      $past(obi_req.req) && !$past(gnt) |-> obi_req.req && obi_req.addr == $past(obi_req.addr))
    else report_fail("address phase changed before its grant");

  assert property (@(posedge clk) disable iff (!rst_n)
      $past(rsp_valid) && !$past(rsp_ready) |-> rsp_valid && rsp == $past(rsp))
    else report_fail("response changed while rsp_ready was low");

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h806d));
    fetch_req  = '0;
    rsp_ready  = 1'b1;
    stray_en   = 1'b0;
    tag_rule   = 1'b0;
    burst_done = 1'b0;
    @(posedge rst_n);
    @(negedge clk);
    end_test("reset state");
    // Back-to-back fetches with the core always ready
    for (int i = 0; i < n_seq; i++) begin
      issue_fetch(32'h1000 + i * 4);
    end
    wait_drain();
    end_test("in-order responses");
    // One fetch at a time so no grant sees the fault of the one before
    tag_rule = 1'b1;
    for (int i = 0; i < n_tag; i++) begin
      addr_v      = $urandom & 32'hffff_fffc;
      addr_v[5:4] = (i % 2 == 1) ? 2'b11 : {1'b0, addr_v[4]};
      issue_fetch(addr_v);
      wait_drain();
    end
    tag_rule = 1'b0;
    end_test("fault tag by address");
    stray_en = 1'b1;
    for (int i = 0; i < n_stray; i++) begin
      issue_fetch($urandom & 32'hffff_fffc);
      repeat ($urandom_range(2, 0)) @(negedge clk);
    end
    wait_drain();
    stray_en = 1'b0;
    end_test("stray parity faults");
    // Core stalls and keeps asking until the credits run out
    rsp_ready       = 1'b0;
    hold_acc        = acc_cnt;
    hold_rv         = rv_cnt;
    fetch_req.valid = 1'b1;
    while (acc_cnt - hold_acc < max_outstnd) begin
      fetch_req.addr = 32'h2000 + (acc_cnt - hold_acc) * 4;
      @(negedge clk);
    end
    fetch_req.addr = 32'h2000 + max_outstnd * 4;
    while (rv_cnt - hold_rv < max_outstnd) @(negedge clk);
    repeat (20) @(negedge clk);
    assert (acc_cnt - hold_acc == max_outstnd)
      else report_fail($sformatf("%0d fetches taken under stall", acc_cnt - hold_acc));
    fetch_req.valid = 1'b0;
    rsp_ready       = 1'b1;
    wait_drain();
    end_test("back-pressure");
    // Random rsp_ready against a steady fetch stream
    fork
      begin
        for (int i = 0; i < n_burst; i++) begin
          issue_fetch(32'h3000 + i * 4);
        end
        burst_done = 1'b1;
      end
      begin
        while (!burst_done) begin
          rsp_ready = ($urandom_range(1, 0) == 1);
          @(negedge clk);
        end
      end
    join
    rsp_ready = 1'b1;
    wait_drain();
    end_test("handshake stability");
    if (fault_q.size() != 0) begin
      err_cnt++;
      $display("Bus granted %0d address phases that no fetch asked for", fault_q.size());
    end
    $display("Summary: %0d fetches, %0d responses checked, %0d errors", acc_cnt, rsp_cnt,
      err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog allows 200 cycles per fetch on top of reset
  initial begin
    #((reset_cycles + 200 * n_fetch) * 10);
    $display("Timeout: the fetch tests did not complete in the expected time");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
